/* onfi_nand_ctrl.f */
src/onfi_pkg.sv
src/nand_ctrl_pkg.sv
src/latch_unit.sv
src/io_unit.sv
src/nand_pin_driver.sv
src/command_sequencer.sv
src/nand_master.sv
sim/nand_master_checker.sv
sim/nand_master_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module nand_master_tb -f onfi_nand_ctrl.f \
	-o nand_master_sim \
	&& ./obj_dir/nand_master_sim | tee sim.log \
	|| { echo "build or simulation did not run"; exit 1; }

grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

/* sim/nand_master_checker.sv */
`timescale 1ns/1ps

module nand_master_checker
	import nand_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	input  logic       activate,
	input  logic [5:0] cmd_in,
	input  logic [7:0] data_in,
	input  logic [7:0] data_out,
	input  logic       busy,
	input  logic       nand_cle,
	input  logic       nand_ale,
	input  logic       nand_nwe,
	input  logic       nand_nre,
	input  logic       nand_nce,
	input  logic       nand_nwp,
	input  logic       nand_rnb,
	input  logic [7:0] nand_dq_out,
	input  logic       nand_dq_oe,
	input  logic [7:0] nand_dq_in,
	output int         test_count,
	output int         error_count
);

	// Reference model of the host registers
	logic [7:0] m_addr [5];
	logic [2:0] m_idx;
	logic       m_ce;
	logic       m_wp;
	logic       m_range;

	// Opcode in flight and what it must produce
	host_op_e   cur_op;
	logic       in_test;
	logic       data_check;
	logic       rd_check;
	logic [7:0] exp_data;
	int         busy_cycles;
	int         test_errors;
	logic       saw_rnb_low;
	logic [7:0] rd_seen;
	int         rd_count;
	// Bus cycles as {cle, ale, byte}, so 2xx is a command and 1xx an address
	logic [9:0] got_q [$];
	logic [9:0] exp_q [$];

	// Pin levels at the previous falling clock edge
	logic prev_nreset;
	logic prev_busy;
	logic prev_nwe;
	logic prev_nre;

	// Status layout, range flag over WP over CE, low two bits unused
	function automatic logic [7:0] status_byte();
		return {3'b000, m_range, m_wp, m_ce, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		error_count++;
		test_errors++;
	endtask

	// Pins right after reset is released
	task automatic check_reset_pins();
		test_errors = 0;
		check_value("nand_cle", 16'(nand_cle), 16'd0);
		check_value("nand_ale", 16'(nand_ale), 16'd0);
		check_value("nand_dq_oe", 16'(nand_dq_oe), 16'd0);
		check_value("nand_nwe", 16'(nand_nwe), 16'd1);
		check_value("nand_nre", 16'(nand_nre), 16'd1);
		check_value("nand_nce", 16'(nand_nce), 16'd1);
		check_value("nand_nwp", 16'(nand_nwp), 16'd0);
		check_value("busy", 16'(busy), 16'd0);
		if (test_errors == 0)
			$display("reset values ok");
		else
			$display("reset values wrong, %0d errors", test_errors);
	endtask

	// ----------------------------------------------------------------------
	// Opcode accepted, update the model and build the expected bus log
	// ----------------------------------------------------------------------
	task automatic start_test();
		cur_op = host_op_e'(cmd_in);
		in_test = 1'b1;
		data_check = 1'b0;
		rd_check = 1'b0;
		busy_cycles = 0;
		test_errors = 0;
		saw_rnb_low = 1'b0;
		rd_count = 0;
		got_q.delete();
		exp_q.delete();
		case (cur_op)
			OP_GET_STATUS: begin
				data_check = 1'b1;
				exp_data = status_byte();
			end
			OP_CHIP_ENABLE: m_ce = 1'b1;
			OP_CHIP_DISABLE: m_ce = 1'b0;
			OP_WRITE_PROTECT: m_wp = 1'b1;
			OP_WRITE_ENABLE: m_wp = 1'b0;
			OP_RESET_INDEX: m_idx = 3'd0;
			OP_GET_ADDR_BYTE, OP_SET_ADDR_BYTE: begin
				if (m_idx < 3'd5) begin
					if (cur_op == OP_GET_ADDR_BYTE) begin
						data_check = 1'b1;
						exp_data = m_addr[m_idx];
					end else begin
						m_addr[m_idx] = data_in;
					end
					m_idx = m_idx + 3'd1;
					m_range = 1'b0;
				end else begin
					// Past the end the index wraps and the range flag is set
					m_idx = 3'd0;
					m_range = 1'b1;
				end
			end
			OP_NAND_RESET: exp_q.push_back({2'b10, 8'hff});
			OP_NAND_READ_STATUS: begin
				exp_q.push_back({2'b10, 8'h70});
				rd_check = 1'b1;
			end
			OP_NAND_BLOCK_ERASE: begin
				// Setup, row bytes 2 to 4, confirm
				exp_q.push_back({2'b10, 8'h60});
				for (int i = 2; i < 5; i++)
					exp_q.push_back({2'b01, m_addr[i]});
				exp_q.push_back({2'b10, 8'hd0});
			end
			OP_BYPASS_CMD: exp_q.push_back({2'b10, data_in});
			OP_BYPASS_ADDR: exp_q.push_back({2'b01, data_in});
			OP_BYPASS_DATA_WR: exp_q.push_back({2'b00, data_in});
			OP_BYPASS_DATA_RD: rd_check = 1'b1;
			default: ;
		endcase
	endtask

	// ----------------------------------------------------------------------
	// busy fell, compare everything the opcode touched
	// ----------------------------------------------------------------------
	task automatic finish_test();
		check_value("nand_nce", 16'(nand_nce), 16'(!m_ce));
		check_value("nand_nwp", 16'(nand_nwp), 16'(!m_wp));
		if (data_check)
			check_value("data_out", 16'(data_out), 16'(exp_data));
		// Only reads pulse RE#, and exactly once
		check_value("nre_pulses", 16'(rd_count), rd_check ? 16'd1 : 16'd0);
		// Reads return the byte the chip drove under RE#
		if (rd_check)
			check_value("data_out", 16'(data_out), 16'(rd_seen));
		check_value("bus_cycle_count", 16'(got_q.size()), 16'(exp_q.size()));
		if (got_q.size() == exp_q.size()) begin
			for (int i = 0; i < exp_q.size(); i++)
				check_value("bus_cycle", 16'(got_q[i]), 16'(exp_q[i]));
		end
		// Register opcodes: one busy cycle, busy low two cycles after activate
		if (cur_op <= OP_SET_ADDR_BYTE)
			check_value("busy_cycles", 16'(busy_cycles), 16'd1);
		if (cur_op == OP_NAND_RESET || cur_op == OP_NAND_BLOCK_ERASE) begin
			if (!saw_rnb_low)
				report_error("R/B# never went low while the operation was busy");
			if (!nand_rnb)
				report_error("busy fell while R/B# was still low");
		end
		test_count++;
		if (test_errors == 0)
			$display("test %0d %s ok", test_count, cur_op.name());
		else
			$display("test %0d %s failed with %0d errors", test_count, cur_op.name(),
				test_errors);
		in_test = 1'b0;
	endtask

	// All pins are registered on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < 5; i++)
				m_addr[i] = 8'h00;
			m_idx = 3'd0;
			m_ce = 1'b0;
			m_wp = 1'b1;
			m_range = 1'b0;
			in_test = 1'b0;
			test_count = 0;
			error_count = 0;
			prev_nreset = 1'b0;
			prev_busy = 1'b0;
			prev_nwe = 1'b1;
			prev_nre = 1'b1;
		end else begin
			if (!prev_nreset)
				check_reset_pins();
			if (activate && !busy)
				start_test();
			if (in_test && busy)
				busy_cycles++;
			if (!nand_rnb)
				saw_rnb_low = 1'b1;
			// Chip latches on rising WE#, controller must own the bus then
			if (nand_nwe && !prev_nwe) begin
				got_q.push_back({nand_cle, nand_ale, nand_dq_out});
				check_value("nand_dq_oe", 16'(nand_dq_oe), 16'd1);
			end
			// DUT samples the bus as RE# goes back high, chip owns the bus then
			if (nand_nre && !prev_nre) begin
				rd_seen = nand_dq_in;
				rd_count++;
				check_value("nand_dq_oe", 16'(nand_dq_oe), 16'd0);
			end
			if (in_test && prev_busy && !busy)
				finish_test();
			prev_nreset = 1'b1;
			prev_busy = busy;
			prev_nwe = nand_nwe;
			prev_nre = nand_nre;
		end
	end

endmodule

/* sim/nand_master_tb.sv */
`timescale 1ns/1ps

module nand_master_tb
	import onfi_pkg::*;
	import nand_ctrl_pkg::*;
();

	localparam int NUM_TESTS = 300;
	localparam int CLK_PERIOD = 100;
	// Worst case is an erase with a long R/B# low, far below this
	localparam int CYCLES_PER_TEST = 400;

	logic       clk;
	logic       nreset;
	logic       activate;
	logic [5:0] cmd_in;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic       busy;
	logic       nand_cle;
	logic       nand_ale;
	logic       nand_nwe;
	logic       nand_nre;
	logic       nand_nce;
	logic       nand_nwp;
	logic       nand_rnb = 1'b1;
	logic [7:0] nand_dq_out;
	logic       nand_dq_oe;
	logic [7:0] nand_dq_in = 8'h00;
	int         test_count;
	int         error_count;
	logic [31:0] rng_state;

	// Chip model state
	logic [7:0]  last_cmd;
	int          rnb_cnt;
	logic        chip_prev_nwe;
	logic        chip_prev_nre;
	logic [31:0] rnd;

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One shared stream for stimulus and chip model
	function automatic logic [31:0] draw_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	nand_master i_nand_master (
		.clk, .nreset, .activate, .cmd_in, .data_in, .data_out, .busy,
		.nand_cle, .nand_ale, .nand_nwe, .nand_nre, .nand_nce, .nand_nwp,
		.nand_rnb, .nand_dq_out, .nand_dq_oe, .nand_dq_in
	);

	nand_master_checker i_checker (
		.clk, .nreset, .activate, .cmd_in, .data_in, .data_out, .busy,
		.nand_cle, .nand_ale, .nand_nwe, .nand_nre, .nand_nce, .nand_nwp,
		.nand_rnb, .nand_dq_out, .nand_dq_oe, .nand_dq_in,
		.test_count, .error_count
	);

	// ----------------------------------------------------------------------
	// NAND chip model
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (!nreset) begin
			last_cmd = 8'h00;
			rnb_cnt = 0;
			chip_prev_nwe = 1'b1;
			chip_prev_nre = 1'b1;
			nand_rnb <= 1'b1;
		end else begin
			if (rnb_cnt != 0)
				rnb_cnt--;
			// Commands latch on rising WE# with CLE high
			if (nand_nwe && !chip_prev_nwe && nand_cle) begin
				last_cmd = nand_dq_out;
				// Reset and erase confirm keep the chip busy for 3 to 20 cycles
				if (last_cmd == CMD_RESET || last_cmd == CMD_ERASE_CONFIRM)
					rnb_cnt = 3 + int'(draw_random() % 18);
			end
			// Read byte goes out as soon as RE# falls
			if (!nand_nre && chip_prev_nre) begin
				rnd = draw_random();
				if (last_cmd == CMD_READ_STATUS)
					nand_dq_in <= {rnd[7], 2'b11, rnd[4:0]}; // RDY and ARDY set
				else
					nand_dq_in <= rnd[7:0];
			end
			nand_rnb <= (rnb_cnt == 0);
			chip_prev_nwe = nand_nwe;
			chip_prev_nre = nand_nre;
		end
	end

	// ----------------------------------------------------------------------
	// Host stimulus
	// ----------------------------------------------------------------------
	// Returns once busy has stayed low through a whole cycle
	task automatic wait_idle();
		int low;
		low = 0;
		while (low < 2) begin
			@(posedge clk);
			#5;
			if (busy)
				low = 0;
			else
				low++;
		end
	endtask

	task automatic issue_op(input logic [5:0] op, input logic [7:0] data);
		wait_idle();
		activate = 1'b1;
		cmd_in = op;
		data_in = data;
		@(posedge clk);
		#5;
		activate = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		int op_num;
		clk = 1'b0;
		nreset = 1'b0;
		activate = 1'b0;
		cmd_in = '0;
		data_in = '0;
		rng_state = 32'h9f0;
		repeat (10) @(posedge clk);
		#5;
		nreset = 1'b1;
		// Status first while it still holds its reset value
		issue_op(OP_GET_STATUS, 8'h00);
		for (int i = 1; i < NUM_TESTS; i++) begin
			r = draw_random();
			op_num = int'(r % 15);
			issue_op(6'(op_num), r[23:16]);
		end
		wait_idle();
		$display("tests %0d errors %0d", test_count, error_count);
		if (error_count == 0 && test_count == NUM_TESTS) begin
			$display("PASS: all tests");
		end else begin
			if (test_count != NUM_TESTS)
				$display("ERROR: only %0d of %0d tests completed", test_count, NUM_TESTS);
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("ERROR: run did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* src/command_sequencer.sv */
`timescale 1ns/1ps

module command_sequencer
	import onfi_pkg::*;
	import nand_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	// Host side
	input  logic       activate,
	input  logic [5:0] cmd_in,
	input  logic [7:0] data_in,
	output logic [7:0] data_out,
	output logic       busy,
	// Chip control pins owned here
	output logic       nand_nce,
	output logic       nand_nwp,
	input  logic       nand_rnb,
	// Unit control
	output logic       cle_act,
	output logic       ale_act,
	output logic       wr_act,
	output logic       rd_act,
	output logic [7:0] cle_byte,
	output logic [7:0] ale_byte,
	output logic [7:0] wr_byte,
	input  logic [7:0] rd_byte,
	input  logic       cle_busy,
	input  logic       ale_busy,
	input  logic       wr_busy,
	input  logic       rd_busy
);

	main_state_e state;
	// State to resume after a wait or delay
	main_state_e next_state;
	sub_state_e  sub;
	logic [7:0]  delay;
	// Index register for address byte access
	logic [2:0]  idx;
	// Address byte being sent by erase
	logic [2:0]  addr_ptr;
	logic [7:0]  addr_reg [ADDR_CYCLES];
	logic [7:0]  status;
	// data_in captured with the opcode
	logic [7:0]  host_byte;
	logic        units_idle;

	assign units_idle = !(cle_busy || ale_busy || wr_busy || rd_busy);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= M_RESET;
			next_state <= M_IDLE;
			sub <= MS_BEGIN;
			delay <= '0;
			idx <= '0;
			addr_ptr <= '0;
			status <= STATUS_RESET;
			busy <= 1'b0;
			nand_nce <= 1'b1;
			nand_nwp <= 1'b0;
			cle_act <= 1'b0;
			ale_act <= 1'b0;
			wr_act <= 1'b0;
			rd_act <= 1'b0;
		end else begin
			// Unit activates are single-cycle pulses
			cle_act <= 1'b0;
			ale_act <= 1'b0;
			wr_act <= 1'b0;
			rd_act <= 1'b0;

			case (state)
				M_RESET: begin
					addr_reg <= '{default: '0};
					busy <= 1'b0;
					state <= M_IDLE;
				end

				// ----------------------------------------------------------------------
				// Command interpreter, register opcodes finish right here
				// ----------------------------------------------------------------------
				M_IDLE: begin
					busy <= 1'b0;
					sub <= MS_BEGIN;
					if (activate && !busy) begin
						busy <= 1'b1;
						host_byte <= data_in;
						case (host_op_e'(cmd_in))
							OP_GET_STATUS: data_out <= status;
							OP_CHIP_ENABLE: begin
								nand_nce <= 1'b0;
								status[STAT_CE] <= 1'b1;
							end
							OP_CHIP_DISABLE: begin
								nand_nce <= 1'b1;
								status[STAT_CE] <= 1'b0;
							end
							OP_WRITE_PROTECT: begin
								nand_nwp <= 1'b0;
								status[STAT_WP] <= 1'b1;
							end
							OP_WRITE_ENABLE: begin
								nand_nwp <= 1'b1;
								status[STAT_WP] <= 1'b0;
							end
							OP_RESET_INDEX: idx <= '0;
							OP_GET_ADDR_BYTE, OP_SET_ADDR_BYTE: begin
								// Out of range wraps the index and flags it
								if (idx < ADDR_CYCLES) begin
									if (cmd_in == OP_GET_ADDR_BYTE)
										data_out <= addr_reg[idx];
									else
										addr_reg[idx] <= data_in;
									idx <= idx + 3'd1;
									status[STAT_RANGE] <= 1'b0;
								end else begin
									if (cmd_in == OP_GET_ADDR_BYTE)
										data_out <= '0;
									idx <= '0;
									status[STAT_RANGE] <= 1'b1;
								end
							end
							OP_NAND_RESET: state <= M_NAND_RESET;
							OP_NAND_READ_STATUS: state <= M_NAND_READ_STATUS;
							OP_NAND_BLOCK_ERASE: state <= M_NAND_BLOCK_ERASE;
							OP_BYPASS_CMD: state <= M_BYPASS_CMD;
							OP_BYPASS_ADDR: state <= M_BYPASS_ADDR;
							OP_BYPASS_DATA_WR: state <= M_BYPASS_DATA_WR;
							OP_BYPASS_DATA_RD: state <= M_BYPASS_DATA_RD;
							default: ;
						endcase
					end
				end

				// ----------------------------------------------------------------------
				// NAND operations
				// ----------------------------------------------------------------------
				M_NAND_RESET: begin
					// FFh, then hold until R/B# comes back
					cle_byte <= CMD_RESET;
					cle_act <= 1'b1;
					delay <= T_WB;
					next_state <= M_IDLE;
					state <= M_WAIT;
				end

				M_NAND_READ_STATUS: begin
					case (sub)
						MS_BEGIN: begin
							cle_byte <= CMD_READ_STATUS;
							cle_act <= 1'b1;
							sub <= MS_SUBMIT_CMD;
							delay <= 8'd1;
							next_state <= M_NAND_READ_STATUS;
							state <= M_WAIT;
						end
						MS_SUBMIT_CMD: begin
							// tWHR before RE# may fall
							delay <= T_WHR;
							sub <= MS_READ0;
							next_state <= M_NAND_READ_STATUS;
							state <= M_DELAY;
						end
						MS_READ0: begin
							rd_act <= 1'b1;
							sub <= MS_READ1;
							delay <= 8'd1;
							next_state <= M_NAND_READ_STATUS;
							state <= M_WAIT;
						end
						default: begin
							// Byte lands in data_out one cycle before busy falls
							data_out <= rd_byte;
							state <= M_IDLE;
						end
					endcase
				end

				M_NAND_BLOCK_ERASE: begin
					next_state <= M_NAND_BLOCK_ERASE;
					case (sub)
						MS_BEGIN: begin
							cle_byte <= CMD_ERASE_SETUP;
							cle_act <= 1'b1;
							addr_ptr <= ERASE_ROW_FIRST;
							sub <= MS_SUBMIT_ADDR;
							delay <= 8'd1;
							state <= M_WAIT;
						end
						MS_SUBMIT_ADDR: begin
							// Row bytes only, one latch cycle each
							ale_byte <= addr_reg[addr_ptr];
							ale_act <= 1'b1;
							addr_ptr <= addr_ptr + 3'd1;
							if (addr_ptr == ADDR_CYCLES - 3'd1)
								sub <= MS_SUBMIT_CMD1;
							delay <= 8'd1;
							state <= M_WAIT;
						end
						MS_SUBMIT_CMD1: begin
							cle_byte <= CMD_ERASE_CONFIRM;
							cle_act <= 1'b1;
							sub <= MS_FINISH;
							// Give R/B# time to drop before it is polled
							delay <= T_WB;
							state <= M_DELAY;
						end
						default: begin
							delay <= T_BERS;
							next_state <= M_IDLE;
							state <= M_WAIT;
						end
					endcase
				end

				// ----------------------------------------------------------------------
				// Raw bus cycles
				// ----------------------------------------------------------------------
				M_BYPASS_CMD: begin
					cle_byte <= host_byte;
					cle_act <= 1'b1;
					delay <= 8'd1;
					next_state <= M_IDLE;
					state <= M_WAIT;
				end

				M_BYPASS_ADDR: begin
					ale_byte <= host_byte;
					ale_act <= 1'b1;
					delay <= 8'd1;
					next_state <= M_IDLE;
					state <= M_WAIT;
				end

				M_BYPASS_DATA_WR: begin
					if (sub == MS_BEGIN) begin
						wr_byte <= host_byte;
						sub <= MS_WRITE;
					end else begin
						wr_act <= 1'b1;
						delay <= 8'd1;
						next_state <= M_IDLE;
						state <= M_WAIT;
					end
				end

				M_BYPASS_DATA_RD: begin
					if (sub == MS_BEGIN) begin
						rd_act <= 1'b1;
						sub <= MS_READ1;
						delay <= T_RR;
						next_state <= M_BYPASS_DATA_RD;
						state <= M_WAIT;
					end else begin
						data_out <= rd_byte;
						state <= M_IDLE;
					end
				end

				// ----------------------------------------------------------------------
				// Waits
				// ----------------------------------------------------------------------
				// Delay first, then units idle and chip ready
				M_WAIT: begin
					if (delay != 8'd0)
						delay <= delay - 8'd1;
					else if (units_idle && nand_rnb)
						state <= next_state;
				end

				M_DELAY: begin
					if (delay != 8'd0)
						delay <= delay - 8'd1;
					else
						state <= next_state;
				end

				default: state <= M_RESET;
			endcase
		end
	end

endmodule

/* src/io_unit.sv */
`timescale 1ns/1ps

module io_unit
	import onfi_pkg::*;
#(
	parameter bit is_read = 1'b0
) (
	input  logic       clk,
	input  logic       nreset,
	input  logic       activate,
	input  logic [7:0] data_in,
	output logic       io_ctrl,
	output logic       busy,
	output logic [7:0] data_out
);

	// RE# or WE# low time, chosen by direction
	localparam logic [3:0] LOW_CYCLES = is_read ? RE_LOW_CYCLES : WE_LOW_CYCLES;

	logic [3:0] cnt;
	logic [7:0] byte_q;
	logic       strobe_rise;

	// Edge where the unit lets RE# or WE# go back high
	assign strobe_rise = busy && (cnt == LOW_CYCLES);

	assign data_out = byte_q;

	// ----------------------------------------------------------------------
	// Strobe shaping
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			cnt <= '0;
			busy <= 1'b0;
			io_ctrl <= 1'b1;
		end else if (!busy) begin
			if (activate) begin
				cnt <= 4'd1;
				busy <= 1'b1;
				io_ctrl <= 1'b0;
			end
		end else if (cnt == IO_CYCLES) begin
			cnt <= '0;
			busy <= 1'b0;
		end else begin
			cnt <= cnt + 4'd1;
			if (strobe_rise)
				io_ctrl <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Data
	// ----------------------------------------------------------------------
	// Writer takes the byte at the start of the cycle
	// Reader samples the bus as RE# rises, the chip drives it while RE# is low
	always_ff @(posedge clk) begin
		if (is_read) begin
			if (strobe_rise)
				byte_q <= data_in;
		end else if (activate && !busy) begin
			byte_q <= data_in;
		end
	end

endmodule

/* src/latch_unit.sv */
`timescale 1ns/1ps

module latch_unit
	import onfi_pkg::*;
#(
	parameter bit is_address = 1'b0
) (
	input  logic       clk,
	input  logic       nreset,
	input  logic       activate,
	input  logic [7:0] data_in,
	output logic       latch_ctrl,
	output logic       write_enable,
	output logic       busy,
	output logic [7:0] data_out
);

	// Position inside the latch cycle, 1 on the first busy cycle
	logic [3:0] cnt;
	// Byte on the bus for this cycle
	logic [7:0] byte_q;

	assign data_out = byte_q;

	// ----------------------------------------------------------------------
	// Cycle shaping
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			cnt <= '0;
			busy <= 1'b0;
			latch_ctrl <= 1'b0;
			write_enable <= 1'b1;
		end else if (!busy) begin
			// Start on the cycle after activate
			if (activate) begin
				cnt <= 4'd1;
				busy <= 1'b1;
				latch_ctrl <= 1'b1;
				write_enable <= 1'b0;
			end
		end else if (cnt == LATCH_CYCLES) begin
			// Cycle over, CLE or ALE drops with busy
			cnt <= '0;
			busy <= 1'b0;
			latch_ctrl <= 1'b0;
		end else begin
			cnt <= cnt + 4'd1;
			// Rising WE# latches the byte in the chip
			if (cnt == WE_LOW_CYCLES)
				write_enable <= 1'b1;
		end
	end

	// Byte register, held for the whole cycle
	always_ff @(posedge clk) begin
		if (activate && !busy)
			byte_q <= data_in;
		else if (busy && cnt == LATCH_CYCLES && !is_address)
			byte_q <= '0; // command latch does not keep a stale opcode
	end

endmodule

/* src/nand_ctrl_pkg.sv */
package nand_ctrl_pkg;

	// ----------------------------------------------------------------------
	// Host opcodes, sampled from cmd_in on activate
	// ----------------------------------------------------------------------
	typedef enum logic [5:0] {
		// Register-only opcodes
		OP_GET_STATUS       = 6'h00,
		OP_CHIP_ENABLE      = 6'h01,
		OP_CHIP_DISABLE     = 6'h02,
		OP_WRITE_PROTECT    = 6'h03,
		OP_WRITE_ENABLE     = 6'h04,
		OP_RESET_INDEX      = 6'h05,
		OP_GET_ADDR_BYTE    = 6'h06,
		OP_SET_ADDR_BYTE    = 6'h07,
		// Full NAND operations
		OP_NAND_RESET       = 6'h08,
		OP_NAND_READ_STATUS = 6'h09,
		OP_NAND_BLOCK_ERASE = 6'h0a,
		// Single raw bus cycles
		OP_BYPASS_CMD       = 6'h0b,
		OP_BYPASS_ADDR      = 6'h0c,
		OP_BYPASS_DATA_WR   = 6'h0d,
		OP_BYPASS_DATA_RD   = 6'h0e
	} host_op_e;

	// Address bytes held in the current address register
	localparam logic [2:0] ADDR_CYCLES = 3'd5;

	// Main FSM states
	typedef enum logic [4:0] {
		M_RESET,
		M_IDLE,
		M_WAIT,
		M_DELAY,
		M_NAND_RESET,
		M_NAND_READ_STATUS,
		M_NAND_BLOCK_ERASE,
		M_BYPASS_CMD,
		M_BYPASS_ADDR,
		M_BYPASS_DATA_WR,
		M_BYPASS_DATA_RD
	} main_state_e;

	// Steps inside one NAND operation
	typedef enum logic [3:0] {
		MS_BEGIN,
		MS_SUBMIT_CMD,
		MS_SUBMIT_ADDR,
		MS_SUBMIT_CMD1,
		MS_WRITE,
		MS_READ0,
		MS_READ1,
		MS_FINISH
	} sub_state_e;

	// Status register bits
	localparam logic [2:0] STAT_CE    = 3'd2;
	localparam logic [2:0] STAT_WP    = 3'd3;
	localparam logic [2:0] STAT_RANGE = 3'd4;

	// Chip disabled and write protected out of reset
	localparam logic [7:0] STATUS_RESET = 8'h08;

endpackage

/* src/nand_master.sv */
`timescale 1ns/1ps

module nand_master (
	input  logic       clk,
	input  logic       nreset,
	// Host port
	input  logic       activate,
	input  logic [5:0] cmd_in,
	input  logic [7:0] data_in,
	output logic [7:0] data_out,
	output logic       busy,
	// NAND pins
	output logic       nand_cle,
	output logic       nand_ale,
	output logic       nand_nwe,
	output logic       nand_nre,
	output logic       nand_nce,
	output logic       nand_nwp,
	input  logic       nand_rnb,
	output logic [7:0] nand_dq_out,
	output logic       nand_dq_oe,
	input  logic [7:0] nand_dq_in
);

	// Command latch
	logic       cle_act, cle_latch_ctrl, cle_write_enable, cle_busy;
	logic [7:0] cle_byte, cle_data;
	// Address latch
	logic       ale_act, ale_latch_ctrl, ale_write_enable, ale_busy;
	logic [7:0] ale_byte, ale_data;
	// Data write and read
	logic       wr_act, wr_write_enable, wr_busy;
	logic [7:0] wr_byte, wr_data;
	logic       rd_act, rd_ctrl, rd_busy;
	logic [7:0] rd_byte;

	command_sequencer i_command_sequencer (
		.clk, .nreset, .activate, .cmd_in, .data_in, .data_out, .busy,
		.nand_nce, .nand_nwp, .nand_rnb,
		.cle_act, .ale_act, .wr_act, .rd_act,
		.cle_byte, .ale_byte, .wr_byte, .rd_byte,
		.cle_busy, .ale_busy, .wr_busy, .rd_busy
	);

	latch_unit #(.is_address(1'b0)) i_cmd_latch (
		.clk, .nreset, .activate(cle_act), .data_in(cle_byte),
		.latch_ctrl(cle_latch_ctrl), .write_enable(cle_write_enable),
		.busy(cle_busy), .data_out(cle_data)
	);

	latch_unit #(.is_address(1'b1)) i_addr_latch (
		.clk, .nreset, .activate(ale_act), .data_in(ale_byte),
		.latch_ctrl(ale_latch_ctrl), .write_enable(ale_write_enable),
		.busy(ale_busy), .data_out(ale_data)
	);

	io_unit #(.is_read(1'b0)) i_io_wr (
		.clk, .nreset, .activate(wr_act), .data_in(wr_byte),
		.io_ctrl(wr_write_enable), .busy(wr_busy), .data_out(wr_data)
	);

	// Reader samples the pin bus directly
	io_unit #(.is_read(1'b1)) i_io_rd (
		.clk, .nreset, .activate(rd_act), .data_in(nand_dq_in),
		.io_ctrl(rd_ctrl), .busy(rd_busy), .data_out(rd_byte)
	);

	nand_pin_driver i_nand_pin_driver (
		.clk, .nreset,
		.cle_latch_ctrl, .cle_write_enable, .cle_busy, .cle_data,
		.ale_latch_ctrl, .ale_write_enable, .ale_busy, .ale_data,
		.wr_write_enable, .wr_busy, .wr_data, .rd_ctrl,
		.nand_cle, .nand_ale, .nand_nwe, .nand_nre, .nand_dq_out, .nand_dq_oe
	);

endmodule

/* src/nand_pin_driver.sv */
`timescale 1ns/1ps

module nand_pin_driver (
	input  logic       clk,
	input  logic       nreset,
	input  logic       cle_latch_ctrl,
	input  logic       cle_write_enable,
	input  logic       cle_busy,
	input  logic [7:0] cle_data,
	input  logic       ale_latch_ctrl,
	input  logic       ale_write_enable,
	input  logic       ale_busy,
	input  logic [7:0] ale_data,
	input  logic       wr_write_enable,
	input  logic       wr_busy,
	input  logic [7:0] wr_data,
	input  logic       rd_ctrl,
	output logic       nand_cle,
	output logic       nand_ale,
	output logic       nand_nwe,
	output logic       nand_nre,
	output logic [7:0] nand_dq_out,
	output logic       nand_dq_oe
);

	// All pins one cycle behind the units, glitch free
	always_ff @(posedge clk) begin
		if (!nreset) begin
			nand_cle <= 1'b0;
			nand_ale <= 1'b0;
			nand_nwe <= 1'b1;
			nand_nre <= 1'b1;
			nand_dq_out <= '0;
			nand_dq_oe <= 1'b0;
		end else begin
			nand_cle <= cle_latch_ctrl;
			nand_ale <= ale_latch_ctrl;
			// Any unit pulling WE# low wins
			nand_nwe <= cle_write_enable & ale_write_enable & wr_write_enable;
			nand_nre <= rd_ctrl;
			// Bus byte, command over address over data
			if (cle_busy)
				nand_dq_out <= cle_data;
			else if (ale_busy)
				nand_dq_out <= ale_data;
			else if (wr_busy)
				nand_dq_out <= wr_data;
			else
				nand_dq_out <= '0;
			// Controller owns the bus during any write-side cycle
			nand_dq_oe <= cle_busy | ale_busy | wr_busy;
		end
	end

endmodule

/* src/onfi_pkg.sv */
package onfi_pkg;

	// ----------------------------------------------------------------------
	// NAND command bytes
	// ----------------------------------------------------------------------

	// Puts the target into its power-on state, R/B# drops while busy
	localparam logic [7:0] CMD_RESET         = 8'hff;
	// Status byte follows on the next data read cycle
	localparam logic [7:0] CMD_READ_STATUS   = 8'h70;
	// Block erase is setup byte, three row address bytes, confirm byte
	localparam logic [7:0] CMD_ERASE_SETUP   = 8'h60;
	localparam logic [7:0] CMD_ERASE_CONFIRM = 8'hd0;

	// ----------------------------------------------------------------------
	// Wait counts, in clock cycles
	// ----------------------------------------------------------------------

	// WE# high to R/B# low
	localparam logic [7:0] T_WB   = 8'd6;
	// WE# high to RE# low, used before the status read
	localparam logic [7:0] T_WHR  = 8'd4;
	// Ready to RE# low
	localparam logic [7:0] T_RR   = 8'd3;
	// Erase time, far below a real part so simulation stays short
	localparam logic [7:0] T_BERS = 8'd2;

	// ----------------------------------------------------------------------
	// Bus cycle shapes
	// ----------------------------------------------------------------------

	// Whole command or address latch cycle
	localparam logic [3:0] LATCH_CYCLES  = 4'd4;
	// WE# low part of a latch or data write cycle
	localparam logic [3:0] WE_LOW_CYCLES = 4'd2;
	// Whole data read or write cycle
	localparam logic [3:0] IO_CYCLES     = 4'd4;
	// RE# low part of a data read cycle
	localparam logic [3:0] RE_LOW_CYCLES = 4'd2;

	// Erase sends only the row address, which starts at address byte 2
	localparam logic [2:0] ERASE_ROW_FIRST = 3'd2;

endpackage
